// ==== timetag.f ====
+incdir+.
timetag_cmd_pkg.sv
timetag_sample_pkg.sv
cmd_decoder.sv
detector_timetagger.sv
sample_buffer.sv
sample_serializer.sv
timetag.sv
timetag_checker.sv
tb_timetag.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -f timetag.f --top-module tb_timetag
	out="$$(./obj_dir/Vtb_timetag +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

// ==== tb_timetag.sv ====
`timescale 1ns/10ps
`include "timetag_config.svh"

module tb_timetag;
	import timetag_cmd_pkg::*;
	import timetag_sample_pkg::*;

	logic       clk;
	logic       rst_n;
	logic       cmd_wr;
	cmd_byte_t  cmd_in;
	det_mask_t  detectors;
	logic       data_accepted;
	logic       request_length;
	det_mask_t  laser_en;
	logic       data_avail;
	out_byte_t  data;
	length_t    length;
	int         seed;
	int         errors;
	int         delivered;
	int         dropped;
	int         dropped_before;
	logic       m_operate;
	logic       m_clear;
	det_mask_t  m_laser;
	det_mask_t  m_det_prev;
	timestamp_t m_ts;
	logic       m_valid; // model of the sample register feeding the buffer.
	sample_t    m_sample;
	sample_t    m_fifo [$];
	length_t    m_length;
	logic       m_send;
	int         m_idx;
	sample_t    m_cur;
	sample_t    rx_word; // bytes collected on the host side.
	int         rx_idx;

	timetag timetag_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.cmd_wr         (cmd_wr),
		.cmd_in         (cmd_in),
		.detectors      (detectors),
		.data_accepted  (data_accepted),
		.request_length (request_length),
		.laser_en       (laser_en),
		.data_avail     (data_avail),
		.data           (data),
		.length         (length)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic compare(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual)
		begin
			$display("ERROR %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	// advances the model over one rising edge, using the inputs driven before it.
	task automatic model_edge();
		det_mask_t hits;
		logic      do_write;
		logic      do_pop;
		hits     = detectors & ~m_det_prev;
		do_write = m_valid && (m_fifo.size() < `TT_FIFO_DEPTH);
		do_pop   = !m_send && (m_fifo.size() > 0);
		if (m_valid && !do_write)
			dropped++;
		if (do_pop)
		begin
			m_cur  = m_fifo.pop_front();
			m_send = 1'b1;
			m_idx  = 0;
		end
		else if (m_send && data_accepted)
		begin
			if (m_idx == 5)
				m_send = 1'b0; // six bytes per sample.
			else
				m_idx++;
		end
		if (do_write)
			m_fifo.push_back(m_sample);
		if (request_length)
			m_length = '0;
		else if (do_write)
			m_length++;
		m_valid  = m_operate && (hits != 4'h0);
		m_sample = {m_laser, hits, m_ts};
		if (m_clear)
			m_ts = '0;
		else if (m_operate)
			m_ts++;
		m_clear = 1'b0;
		if (cmd_wr)
		begin
			case (cmd_in[7:4])
				OP_START:
					m_operate = 1'b1;
				OP_STOP:
					m_operate = 1'b0;
				OP_CLEAR:
					m_clear = 1'b1;
				OP_LASER:
					m_laser = cmd_in[3:0];
				default:
					;
			endcase
		end
		m_det_prev = detectors;
	endtask

	task automatic check_outputs();
		compare("laser_en", 64'(m_laser), 64'(laser_en));
		compare("length", 64'(m_length), 64'(length));
		compare("data_avail", 64'(m_send), 64'(data_avail));
		if (m_send)
			compare("data", 64'(m_cur[8*m_idx +: 8]), 64'(data));
	endtask

	// drives at the falling edge, then checks at the next falling edge.
	task automatic tick(input logic wr, input cmd_byte_t cmd, input det_mask_t det,
			input logic acc, input logic req);
		cmd_wr         = wr;
		cmd_in         = cmd;
		detectors      = det;
		data_accepted  = acc;
		request_length = req;
		if (data_avail && data_accepted)
		begin
			rx_word[8*rx_idx +: 8] = data;
			rx_idx++;
			if (rx_idx == 6)
			begin
				compare("sample", 64'(m_cur), 64'(rx_word));
				delivered++;
				rx_idx = 0;
			end
		end
		@(negedge clk);
		model_edge();
		check_outputs();
	endtask

	task automatic random_tick(input logic [7:0] det_level, input logic acc_random);
		logic [31:0] r;
		det_mask_t   det;
		int          i;
		for (i = 0; i < `TT_NUM_DET; i++)
		begin
			r      = $random(seed);
			det[i] = (r[7:0] < det_level);
		end
		r = $random(seed);
		tick(r[4:0] == 5'd0, r[15:8] & 8'h7f, det, acc_random & r[31], r[21:16] == 6'd0);
	endtask

	task automatic wait_avail(input int limit);
		int n;
		n = 0;
		while (!data_avail && n < limit)
		begin
			tick(1'b0, 8'h00, 4'h0, 1'b0, 1'b0);
			n++;
		end
		if (!data_avail)
		begin
			$display("timeout: data_avail did not rise within %0d cycles", limit);
			errors++;
		end
	endtask

	task automatic drain(input int limit);
		int n;
		n = 0;
		while ((m_send || m_valid || m_fifo.size() > 0 || data_avail) && n < limit)
		begin
			tick(1'b0, 8'h00, 4'h0, 1'b1, 1'b0);
			n++;
		end
		if (m_send || m_valid || m_fifo.size() > 0 || data_avail)
		begin
			$display("timeout: data_avail still high after %0d cycles of draining", limit);
			errors++;
		end
	endtask

	initial
	begin
		seed = 32'h144a;
		errors = 0;
		delivered = 0;
		dropped = 0;
		rst_n = 1'b0;
		cmd_wr = 1'b0;
		cmd_in = '0;
		detectors = '0;
		data_accepted = 1'b0;
		request_length = 1'b0;
		m_operate = 1'b0;
		m_clear = 1'b0;
		m_laser = '0;
		m_det_prev = '0;
		m_ts = '0;
		m_valid = 1'b0;
		m_length = '0;
		m_send = 1'b0;
		m_idx = 0;
		rx_idx = 0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		compare("reset data_avail", 64'd0, 64'(data_avail));
		compare("reset laser_en", 64'd0, 64'(laser_en));
		compare("reset length", 64'd0, 64'(length));
		tick(1'b1, {OP_LASER, 4'ha}, 4'h0, 1'b0, 1'b0);
		compare("laser command", 64'ha, 64'(laser_en));
		tick(1'b1, 8'hb3, 4'h0, 1'b0, 1'b0); // opcode 11 is not defined.
		compare("unknown opcode", 64'ha, 64'(laser_en));
		tick(1'b1, {OP_START, 4'h0}, 4'h0, 1'b0, 1'b0);
		repeat (2000) random_tick(8'd4, 1'b1);
		drain(400);
		tick(1'b1, {OP_START, 4'h0}, 4'h0, 1'b0, 1'b0);
		dropped_before = dropped;
		repeat (150) random_tick(8'd80, 1'b0); // host stalls, so the buffer overflows.
		wait_avail(50);
		drain(400);
		if (dropped == dropped_before)
		begin
			$display("overflow phase dropped no samples");
			errors++;
		end
		tick(1'b0, 8'h00, 4'h0, 1'b0, 1'b1);
		compare("length after request", 64'd0, 64'(length));
		errors += timetag_i.timetag_checker_i.failures;
		$display("errors %0d, samples delivered %0d, samples dropped %0d",
			errors, delivered, dropped);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== timetag_checker.sv ====
`timescale 1ns/10ps
`include "timetag_config.svh"

module timetag_checker (
	input logic                          clk,
	input logic                          rst_n,
	input logic                          data_avail,
	input logic                          data_accepted,
	input timetag_sample_pkg::out_byte_t data,
	input logic                          pop,
	input logic                          buf_empty,
	input logic                          sample_valid
);
	int unsigned fill; // samples the buffer should be holding.
	int unsigned failures = 0;
	logic        wr_ok;

	assign wr_ok = sample_valid && (fill < `TT_FIFO_DEPTH);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			fill <= 0;
		else if (wr_ok && !pop)
			fill <= fill + 1;
		else if (pop && !wr_ok)
			fill <= fill - 1;
	end

	reset_idle: assert property (@(posedge clk) !rst_n |-> !data_avail)
	else
	begin
		$error("data_avail high during reset");
		failures++;
	end

	data_hold: assert property (@(posedge clk) disable iff (!rst_n)
		data_avail && !data_accepted |=> $stable(data))
	else
	begin
		$error("data changed before the host accepted it");
		failures++;
	end

	pop_nonempty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> fill != 0)
	else
	begin
		$error("pop while the buffer holds no samples");
		failures++;
	end

	empty_fill: assert property (@(posedge clk) disable iff (!rst_n) !buf_empty |-> fill != 0)
	else
	begin
		$error("buffer reports data with a fill level of zero");
		failures++;
	end

endmodule

bind timetag timetag_checker timetag_checker_i (
	.clk           (clk),
	.rst_n         (rst_n),
	.data_avail    (data_avail),
	.data_accepted (data_accepted),
	.data          (data),
	.pop           (pop),
	.buf_empty     (buf_empty),
	.sample_valid  (sample_valid)
);

// ==== timetag.sv ====
`timescale 1ns/10ps

module timetag (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          cmd_wr,
	input  timetag_cmd_pkg::cmd_byte_t    cmd_in,
	input  timetag_sample_pkg::det_mask_t detectors,
	input  logic                          data_accepted,
	input  logic                          request_length,
	output timetag_sample_pkg::det_mask_t laser_en,
	output logic                          data_avail,
	output timetag_sample_pkg::out_byte_t data,
	output timetag_sample_pkg::length_t   length
);
	import timetag_sample_pkg::*;

	logic    operate;
	logic    clear;
	logic    sample_valid;
	sample_t sample;
	sample_t buf_sample;
	logic    buf_empty;
	logic    pop;

	cmd_decoder cmd_decoder_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.cmd_wr   (cmd_wr),
		.cmd_in   (cmd_in),
		.operate  (operate),
		.clear    (clear),
		.laser_en (laser_en)
	);

	detector_timetagger detector_timetagger_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.operate      (operate),
		.clear        (clear),
		.laser_en     (laser_en),
		.detectors    (detectors),
		.sample_valid (sample_valid),
		.sample       (sample)
	);

	sample_buffer sample_buffer_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.wr             (sample_valid),
		.wr_sample      (sample),
		.pop            (pop),
		.request_length (request_length),
		.buf_sample     (buf_sample),
		.buf_empty      (buf_empty),
		.length         (length)
	);

	sample_serializer sample_serializer_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.buf_sample    (buf_sample),
		.buf_empty     (buf_empty),
		.data_accepted (data_accepted),
		.pop           (pop),
		.data_avail    (data_avail),
		.data          (data)
	);

endmodule

// ==== sample_serializer.sv ====
`timescale 1ns/10ps

module sample_serializer (
	input  logic                          clk,
	input  logic                          rst_n,
	input  timetag_sample_pkg::sample_t   buf_sample,
	input  logic                          buf_empty,
	input  logic                          data_accepted,
	output logic                          pop,
	output logic                          data_avail,
	output timetag_sample_pkg::out_byte_t data
);
	import timetag_sample_pkg::*;

	localparam int unsigned LAST_BYTE = $bits(sample_t) / 8 - 1;

	ser_state_t state;
	sample_t    cur;
	logic [2:0] byte_idx;

	assign pop        = (state == SER_IDLE) && !buf_empty;
	assign data_avail = (state == SER_SEND);
	assign data       = cur[8*byte_idx +: 8]; // least significant byte goes out first.

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= SER_IDLE;
			byte_idx <= '0;
		end
		else
		begin
			case (state)
				SER_IDLE:
					if (!buf_empty)
					begin
						state    <= SER_SEND;
						byte_idx <= '0;
					end
				SER_SEND:
					if (data_accepted)
					begin
						if (byte_idx == 3'(LAST_BYTE))
							state <= SER_IDLE;
						else
							byte_idx <= byte_idx + 1'b1;
					end
				default:
					state <= SER_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			cur <= buf_sample;
		end
	end

endmodule

// ==== sample_buffer.sv ====
`timescale 1ns/10ps
`include "timetag_config.svh"

module sample_buffer (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          wr,
	input  timetag_sample_pkg::sample_t   wr_sample,
	input  logic                          pop,
	input  logic                          request_length,
	output timetag_sample_pkg::sample_t   buf_sample,
	output logic                          buf_empty,
	output timetag_sample_pkg::length_t   length
);
	import timetag_sample_pkg::*;

	sample_t mem [`TT_FIFO_DEPTH];

	logic [`TT_FIFO_AW:0] wr_ptr; // top bit is the wrap flag.
	logic [`TT_FIFO_AW:0] rd_ptr;
	logic                 full;
	logic                 wr_en;
	logic                 rd_en;

	assign buf_empty = (wr_ptr == rd_ptr);
	assign full      = (wr_ptr[`TT_FIFO_AW] != rd_ptr[`TT_FIFO_AW]) &&
			   (wr_ptr[`TT_FIFO_AW-1:0] == rd_ptr[`TT_FIFO_AW-1:0]);

	assign wr_en = wr & ~full; // samples that arrive while full are lost.
	assign rd_en = pop & ~buf_empty;

	assign buf_sample = mem[rd_ptr[`TT_FIFO_AW-1:0]];

	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			mem[wr_ptr[`TT_FIFO_AW-1:0]] <= wr_sample;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			length <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			if (request_length)
				length <= '0; // a readout request beats a write in the same cycle.
			else if (wr_en)
				length <= length + 1'b1;
		end
	end

endmodule

// ==== detector_timetagger.sv ====
`timescale 1ns/10ps

module detector_timetagger (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          operate,
	input  logic                          clear,
	input  timetag_sample_pkg::det_mask_t laser_en,
	input  timetag_sample_pkg::det_mask_t detectors,
	output logic                          sample_valid,
	output timetag_sample_pkg::sample_t   sample
);
	import timetag_sample_pkg::*;

	timestamp_t timestamp;
	det_mask_t  det_prev;
	det_mask_t  hits;
	logic       any_hit;

	// a hit is a detector that is high now and was low at the previous edge.
	assign hits    = detectors & ~det_prev;
	assign any_hit = |hits;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			timestamp <= '0;
		end
		else if (clear)
		begin
			timestamp <= '0;
		end
		else if (operate)
		begin
			timestamp <= timestamp + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			det_prev <= '0;
		end
		else
		begin
			det_prev <= detectors;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sample_valid <= 1'b0;
		end
		else
		begin
			sample_valid <= operate & any_hit;
		end
	end

	// The timestamp captured here is the value from the cycle in which the detector rose.
	always_ff @(posedge clk)
	begin
		if (operate && any_hit)
		begin
			sample <= {laser_en, hits, timestamp};
		end
	end

endmodule

// ==== cmd_decoder.sv ====
`timescale 1ns/10ps

module cmd_decoder (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          cmd_wr,
	input  timetag_cmd_pkg::cmd_byte_t    cmd_in,
	output logic                          operate,
	output logic                          clear,
	output timetag_sample_pkg::det_mask_t laser_en
);
	import timetag_cmd_pkg::*;

	cmd_op_t  op;
	cmd_arg_t arg;

	assign op  = cmd_op_t'(cmd_in[7:4]);
	assign arg = cmd_in[3:0];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			operate  <= 1'b0;
			clear    <= 1'b0;
			laser_en <= '0;
		end
		else
		begin
			clear <= 1'b0; // clear only lasts for the cycle after the strobe.
			if (cmd_wr)
			begin
				case (op)
					OP_NOP:
						;
					OP_START:
						operate <= 1'b1;
					OP_STOP:
						operate <= 1'b0;
					OP_CLEAR:
						clear <= 1'b1;
					OP_LASER:
						laser_en <= arg;
					default:
						; // unknown opcodes are ignored.
				endcase
			end
		end
	end

endmodule

// ==== timetag_sample_pkg.sv ====
`include "timetag_config.svh"

package timetag_sample_pkg;

	typedef logic [`TT_TS_W-1:0] timestamp_t;

	// used both for the detector hits and for the laser pattern.
	typedef logic [`TT_NUM_DET-1:0] det_mask_t;

	// {laser pattern, detector hits, timestamp}, 48 bits in total.
	typedef logic [2*`TT_NUM_DET+`TT_TS_W-1:0] sample_t;

	typedef logic [7:0] out_byte_t;

	typedef logic [15:0] length_t;

	typedef enum logic {
		SER_IDLE,
		SER_SEND
	} ser_state_t;

endpackage

// ==== timetag_cmd_pkg.sv ====
package timetag_cmd_pkg;

	// one host byte is one complete command.
	typedef logic [7:0] cmd_byte_t;

	// low nibble of the command byte.
	typedef logic [3:0] cmd_arg_t;

	// high nibble of the command byte selects the operation.
	typedef enum logic [3:0] {
		OP_NOP   = 4'd0,
		OP_START = 4'd1, // timestamp starts counting.
		OP_STOP  = 4'd2, // timestamp holds.
		OP_CLEAR = 4'd3, // timestamp goes to zero.
		OP_LASER = 4'd4  // argument becomes the laser pattern.
	} cmd_op_t;

endpackage

// ==== timetag_config.svh ====
`ifndef TIMETAG_CONFIG_SVH
`define TIMETAG_CONFIG_SVH

// Samples held in the buffer between the timetagger and the serializer.
`define TT_FIFO_DEPTH 16

// Pointer width of the buffer, log2 of the depth.
`define TT_FIFO_AW 4

// Width of the free-running timestamp counter.
`define TT_TS_W 40

// One laser enable per detector channel.
`define TT_NUM_DET 4

`endif
